/* controlUnit.sv */
// control unit
// decodes the opcode, and the function field of register-format words,
// into alu operation, operand and writeback selects and control bits
// unknown opcodes raise err and leave every select at its nop value
`timescale 1ns/100ps
module controlUnit (
   input  decodePkg::instrWord_t instr,
   output logic [3:0]            aluOp,
   output logic [1:0]            bSrc,
   output logic [1:0]            wbSel,
   output logic [1:0]            regDest,
   output logic                  memWrt,
   output logic                  readEn,
   output logic                  regWrtOut,
   output logic                  stuSel,
   output logic                  zeroSel,
   output logic [2:0]            brchSig,
   output logic                  jmpSel,
   output logic                  halt,
   output logic                  err
);
   import decodePkg::*;

   logic [4:0] opcode;

   // shift group or arithmetic group, then one of four in the group
   function automatic logic [3:0] aluFromSel(input logic shift, input logic [1:0] sel);
      case ({shift, sel})
         3'b000:  return aluAdd;
         3'b001:  return aluSub;
         3'b010:  return aluXor;
         3'b011:  return aluAndn;
         3'b100:  return aluRol;
         3'b101:  return aluSll;
         3'b110:  return aluRor;
         default: return aluSrl;
      endcase
   endfunction

   assign opcode = instr.iView.opcode;

   always_comb begin
      // nop values
      aluOp     = aluAdd;
      bSrc      = bSrcZero;
      wbSel     = wbAlu;
      regDest   = destRs;
      memWrt    = 1'b0;
      readEn    = 1'b0;
      regWrtOut = 1'b0;
      stuSel    = 1'b0;
      zeroSel   = 1'b0;
      brchSig   = 3'b000;
      jmpSel    = 1'b0;
      halt      = 1'b0;
      err       = 1'b0;
      case (opcode)
         opHalt: halt = 1'b1;
         opNop: ;  // defaults already
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
            aluOp     = aluFromSel(opcode[2], opcode[1:0]);
            bSrc      = bSrcImm5;
            zeroSel   = opcode[2] | opcode[1];  // only addi and subi sign-extend
            regWrtOut = 1'b1;
            regDest   = destRt;
         end
         opAluRR, opShiftRR: begin
            aluOp     = aluFromSel(~opcode[0], instr.rView.func);
            bSrc      = bSrcRegB;
            regWrtOut = 1'b1;
            regDest   = destRd;
         end
         opSt: begin
            bSrc   = bSrcImm5;  // address is rs + imm5
            memWrt = 1'b1;
         end
         opLd: begin
            bSrc      = bSrcImm5;
            readEn    = 1'b1;
            wbSel     = wbMem;
            regWrtOut = 1'b1;
            regDest   = destRt;
         end
         opStu: begin
            bSrc      = bSrcImm5;
            memWrt    = 1'b1;
            stuSel    = 1'b1;   // store data is regB
            regWrtOut = 1'b1;   // rs gets the effective address
            regDest   = destRs;
         end
         opLbi: begin
            aluOp     = aluPassB;
            bSrc      = bSrcImm8;
            wbSel     = wbImm;
            regWrtOut = 1'b1;
         end
         opSlbi: begin
            aluOp     = aluSlbi;
            bSrc      = bSrcImm8;
            zeroSel   = 1'b1;
            regWrtOut = 1'b1;
         end
         opBeqz, opBnez, opBltz, opBgez: brchSig = {1'b1, opcode[1:0]};  // alu passes rs
         opJ: jmpSel = 1'b1;
         opJal: begin
            jmpSel    = 1'b1;
            wbSel     = wbPc2;  // link address
            regWrtOut = 1'b1;
            regDest   = destR7;
         end
         default: err = 1'b1;
      endcase
   end

endmodule

/* decode.sv */
// decode stage
// reads operands, builds the immediates, selects the b operand and
// registers one decoded instruction for execute
// an empty queue decodes as nop with decValid low
`timescale 1ns/100ps
module decode (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         popValid,
   input  logic [decodePkg::dataW-1:0]   popWord,
   output logic                         popReady,
   input  logic                         exHold,
   input  logic                         regWrt,
   input  logic [decodePkg::regSelW-1:0] wrtReg,
   input  logic [decodePkg::dataW-1:0]   wbData,
   output logic                         decValid,
   output logic [3:0]                   aluOp,
   output logic [decodePkg::dataW-1:0]   inA,
   output logic [decodePkg::dataW-1:0]   inB,
   output logic [decodePkg::dataW-1:0]   wrtData,
   output logic [decodePkg::dataW-1:0]   imm8,
   output logic [decodePkg::dataW-1:0]   imm11,
   output logic [decodePkg::regSelW-1:0] wrtRegOut,
   output logic                         regWrtOut,
   output logic                         memWrt,
   output logic                         readEn,
   output logic [1:0]                   wbSel,
   output logic [2:0]                   brchSig,
   output logic                         jmpSel,
   output logic                         halt,
   output logic                         err
);
   import decodePkg::*;

   instrWord_t         instr;
   logic [dataW-1:0]   regA, regB, imm5, imm8Nxt, imm11Nxt, inBNxt;
   logic [regSelW-1:0] wrtRegNxt;
   logic [3:0]         aluOpNxt;
   logic [2:0]         brchNxt;
   logic [1:0]         bSrc, wbSelNxt, regDest;
   logic               memWrtNxt, readEnNxt, regWrtNxt, jmpNxt, haltNxt, errNxt;
   logic               stuSel, zeroSel;

   assign popReady = !exHold;
   assign instr    = popValid ? popWord : nopWord;  // bubble decodes as nop

   regFile regFile0 (
      .clk(clk), .rstN(rstN),
      .rdSel1(instr.iView.rs), .rdSel2(instr.rView.rt),
      .wrSel(wrtReg), .wrData(wbData), .wrEn(regWrt),
      .rdData1(regA), .rdData2(regB)
   );

   controlUnit controlUnit0 (
      .instr(instr), .aluOp(aluOpNxt), .bSrc(bSrc), .wbSel(wbSelNxt),
      .regDest(regDest), .memWrt(memWrtNxt), .readEn(readEnNxt),
      .regWrtOut(regWrtNxt), .stuSel(stuSel), .zeroSel(zeroSel),
      .brchSig(brchNxt), .jmpSel(jmpNxt), .halt(haltNxt), .err(errNxt)
   );

   // imm8 and imm11 span the rd and rs fields of the immediate view
   assign imm5 = zeroSel ? {11'b0, instr.iView.imm5}
                         : {{11{instr.iView.imm5[4]}}, instr.iView.imm5};
   assign imm8Nxt = zeroSel ? {8'b0, instr.iView.rd, instr.iView.imm5}
                            : {{8{instr.iView.rd[2]}}, instr.iView.rd, instr.iView.imm5};
   assign imm11Nxt = {{5{instr.iView.rs[2]}}, instr.iView.rs, instr.iView.rd, instr.iView.imm5};

   always_comb begin
      case (bSrc)
         bSrcRegB: inBNxt = regB;
         bSrcImm5: inBNxt = imm5;
         bSrcImm8: inBNxt = imm8Nxt;
         default:  inBNxt = '0;
      endcase
      case (regDest)
         destRs:  wrtRegNxt = instr.iView.rs;
         destRt:  wrtRegNxt = instr.rView.rt;
         destRd:  wrtRegNxt = instr.rView.rd;
         default: wrtRegNxt = '1;  // r7, jal link
      endcase
   end

   // control half of the output register
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         decValid  <= 1'b0;
         regWrtOut <= 1'b0;
         memWrt    <= 1'b0;
         readEn    <= 1'b0;
         brchSig   <= 3'b000;
         jmpSel    <= 1'b0;
         halt      <= 1'b0;
         err       <= 1'b0;
      end else if (!exHold) begin
         decValid  <= popValid;
         regWrtOut <= regWrtNxt;
         memWrt    <= memWrtNxt;
         readEn    <= readEnNxt;
         brchSig   <= brchNxt;
         jmpSel    <= jmpNxt;
         halt      <= haltNxt;
         err       <= errNxt;
      end
   end

   // payload half, held with the control half
   always_ff @(posedge clk) begin
      if (!exHold) begin
         aluOp     <= aluOpNxt;
         inA       <= regA;
         inB       <= inBNxt;
         wrtData   <= stuSel ? regB : inBNxt;  // stu stores rt, not the offset
         imm8      <= imm8Nxt;
         imm11     <= imm11Nxt;
         wrtRegOut <= wrtRegNxt;
         wbSel     <= wbSelNxt;
      end
   end

endmodule

/* decodePkg.sv */
// decode package
// word and field widths, opcode map, alu operation codes, select encodings
// and the two views of one instruction word
package decodePkg;

   localparam int dataW   = 16;
   localparam int regSelW = 3;

   // one word, read as immediate format or as register format
   typedef union packed {
      struct packed {
         logic [4:0]         opcode;
         logic [regSelW-1:0] rs;
         logic [regSelW-1:0] rd;
         logic [4:0]         imm5;  // also low bits of imm8 and imm11
      } iView;
      struct packed {
         logic [4:0]         opcode;
         logic [regSelW-1:0] rs;
         logic [regSelW-1:0] rt;
         logic [regSelW-1:0] rd;
         logic [1:0]         func;
      } rView;
   } instrWord_t;

   // opcodes
   localparam logic [4:0] opHalt    = 5'b00000;
   localparam logic [4:0] opNop     = 5'b00001;
   localparam logic [4:0] opJ       = 5'b00100;
   localparam logic [4:0] opJal     = 5'b00110;
   localparam logic [4:0] opAddi    = 5'b01000;
   localparam logic [4:0] opSubi    = 5'b01001;
   localparam logic [4:0] opXori    = 5'b01010;
   localparam logic [4:0] opAndni   = 5'b01011;
   localparam logic [4:0] opBeqz    = 5'b01100;
   localparam logic [4:0] opBnez    = 5'b01101;
   localparam logic [4:0] opBltz    = 5'b01110;
   localparam logic [4:0] opBgez    = 5'b01111;
   localparam logic [4:0] opSt      = 5'b10000;
   localparam logic [4:0] opLd      = 5'b10001;
   localparam logic [4:0] opSlbi    = 5'b10010;
   localparam logic [4:0] opStu     = 5'b10011;
   localparam logic [4:0] opRoli    = 5'b10100;
   localparam logic [4:0] opSlli    = 5'b10101;
   localparam logic [4:0] opRori    = 5'b10110;
   localparam logic [4:0] opSrli    = 5'b10111;
   localparam logic [4:0] opLbi     = 5'b11000;
   localparam logic [4:0] opShiftRR = 5'b11010;  // rol sll ror srl by func
   localparam logic [4:0] opAluRR   = 5'b11011;  // add sub xor andn by func

   // alu operations
   localparam logic [3:0] aluAdd   = 4'h0;
   localparam logic [3:0] aluSub   = 4'h1;
   localparam logic [3:0] aluXor   = 4'h2;
   localparam logic [3:0] aluAndn  = 4'h3;
   localparam logic [3:0] aluRol   = 4'h4;
   localparam logic [3:0] aluSll   = 4'h5;
   localparam logic [3:0] aluRor   = 4'h6;
   localparam logic [3:0] aluSrl   = 4'h7;
   localparam logic [3:0] aluPassB = 4'h8;
   localparam logic [3:0] aluSlbi  = 4'h9;  // (a << 8) | b

   // b operand source
   localparam logic [1:0] bSrcRegB = 2'd0;
   localparam logic [1:0] bSrcImm5 = 2'd1;
   localparam logic [1:0] bSrcImm8 = 2'd2;
   localparam logic [1:0] bSrcZero = 2'd3;

   // writeback source
   localparam logic [1:0] wbAlu = 2'd0;
   localparam logic [1:0] wbMem = 2'd1;
   localparam logic [1:0] wbPc2 = 2'd2;
   localparam logic [1:0] wbImm = 2'd3;

   // destination register field
   localparam logic [1:0] destRs = 2'd0;  // bits 10:8
   localparam logic [1:0] destRt = 2'd1;  // bits 7:5
   localparam logic [1:0] destRd = 2'd2;  // bits 4:2
   localparam logic [1:0] destR7 = 2'd3;

   localparam logic [dataW-1:0] nopWord = {opNop, 11'b0};

endpackage

/* decodeSubsystem.f */
decodePkg.sv
regFile.sv
controlUnit.sv
fetchUnit.sv
instrQueue.sv
decode.sv
decodeSubsystem.sv
tbDecodeSubsystem.sv

/* decodeSubsystem.sv */
// decode subsystem top
// fetch, instruction queue and decode stage in a chain
// wishbone master port out, writeback and execute hold in
`timescale 1ns/100ps
module decodeSubsystem #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         go,
   output logic                         wbCyc,
   output logic                         wbStb,
   output logic                         wbWe,
   output logic [decodePkg::dataW-1:0]   wbAdr,
   input  logic [decodePkg::dataW-1:0]   wbDatI,
   input  logic                         wbAck,
   input  logic                         regWrt,
   input  logic [decodePkg::regSelW-1:0] wrtReg,
   input  logic [decodePkg::dataW-1:0]   wbData,
   input  logic                         exHold,
   output logic                         decValid,
   output logic [3:0]                   aluOp,
   output logic [decodePkg::dataW-1:0]   inA,
   output logic [decodePkg::dataW-1:0]   inB,
   output logic [decodePkg::dataW-1:0]   wrtData,
   output logic [decodePkg::dataW-1:0]   imm8,
   output logic [decodePkg::dataW-1:0]   imm11,
   output logic [decodePkg::regSelW-1:0] wrtRegOut,
   output logic                         regWrtOut,
   output logic                         memWrt,
   output logic                         readEn,
   output logic [1:0]                   wbSel,
   output logic [2:0]                   brchSig,
   output logic                         jmpSel,
   output logic                         halt,
   output logic                         err
);
   import decodePkg::*;

   localparam int spaceW = $clog2(QUEUE_DEPTH+1);

   logic [spaceW-1:0] qSpace;
   logic              pushValid, popValid, popReady;
   logic [dataW-1:0]  pushWord, popWord;

   assign wbWe = 1'b0;  // instruction port only reads

   fetchUnit #(.QUEUE_DEPTH(QUEUE_DEPTH)) fetchUnit0 (
      .clk(clk), .rstN(rstN), .go(go),
      .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wbDatI(wbDatI), .wbAck(wbAck),
      .pushValid(pushValid), .pushWord(pushWord), .qSpace(qSpace)
   );

   instrQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) instrQueue0 (
      .clk(clk), .rstN(rstN),
      .pushValid(pushValid), .pushWord(pushWord), .qSpace(qSpace),
      .popValid(popValid), .popWord(popWord), .popReady(popReady)
   );

   decode decode0 (
      .clk(clk), .rstN(rstN),
      .popValid(popValid), .popWord(popWord), .popReady(popReady), .exHold(exHold),
      .regWrt(regWrt), .wrtReg(wrtReg), .wbData(wbData),
      .decValid(decValid), .aluOp(aluOp), .inA(inA), .inB(inB), .wrtData(wrtData),
      .imm8(imm8), .imm11(imm11), .wrtRegOut(wrtRegOut), .regWrtOut(regWrtOut),
      .memWrt(memWrt), .readEn(readEn), .wbSel(wbSel), .brchSig(brchSig),
      .jmpSel(jmpSel), .halt(halt), .err(err)
   );

endmodule

/* decodeTrace.txt */
# R reg value | P word | all values hex, # starts a comment
# E aluOp inA inB wrtData imm8 imm11 wrtReg regWrt memWrt readEn wbSel brchSig jmpSel halt err
R 0 0A0A
R 1 1111
R 2 2222
R 3 3333
R 4 8004
R 5 0055
R 6 6006
R 7 F00F
P 417E  # addi r3, r1, -2
E 0 1111 FFFE FFFE 007E 017E 3 1 0 0 0 0 0 0 0
P 5555  # xori r2, r5, 0x15
E 2 0055 0015 0015 0055 FD55 2 1 0 0 0 0 0 0 0
P AEE3  # slli r7, r6, 3
E 5 6006 0003 0003 00E3 FEE3 7 1 0 0 0 0 0 0 0
P DA85  # sub r1, r2, r4
E 1 2222 8004 8004 FF85 0285 1 1 0 0 0 0 0 0 0
P D77A  # ror r6, r7, r3
E 6 F00F 3333 3333 007A FF7A 6 1 0 0 0 0 0 0 0
P 8CA4  # ld r5, 4(r4)
E 0 8004 0004 0004 FFA4 FCA4 5 1 0 1 1 0 0 0 0
P 8330  # st r1, -16(r3)
E 0 3333 FFF0 FFF0 0030 0330 3 0 1 0 0 0 0 0 0
P 9AC2  # stu r6, 2(r2)
E 0 2222 0002 6006 FFC2 02C2 2 1 1 0 0 0 0 0 0
P C196  # lbi r1, 0x96
E 8 1111 FF96 FF96 FF96 0196 1 1 0 0 3 0 0 0 0
P 95A5  # slbi r5, 0xA5
E 9 0055 00A5 00A5 00A5 FDA5 5 1 0 0 0 0 0 0 0
P 6CF0  # bnez r4, -16
E 0 8004 0000 0000 FFF0 FCF0 4 0 0 0 0 5 0 0 0
P 3028  # jal 0x028
E 0 0A0A 0000 0000 0028 0028 7 1 0 0 2 0 1 0 0
P 27FC  # j -4
E 0 F00F 0000 0000 FFFC FFFC 7 0 0 0 0 0 1 0 0
P 1344  # opcode 00010 is illegal
E 0 3333 0000 0000 0044 0344 3 0 0 0 0 0 0 0 1
P 0800  # nop
E 0 0A0A 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0
P 0000  # halt
E 0 0A0A 0000 0000 0000 0000 0 0 0 0 0 0 0 1 0

/* fetchUnit.sv */
// instruction fetch
// wishbone classic master reading sequential words from address zero
// each acknowledged word goes into the queue in the cycle of its ack
`timescale 1ns/100ps
module fetchUnit #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rstN,
   input  logic                               go,
   output logic                               wbCyc,
   output logic                               wbStb,
   output logic [decodePkg::dataW-1:0]         wbAdr,
   input  logic [decodePkg::dataW-1:0]         wbDatI,
   input  logic                               wbAck,
   output logic                               pushValid,
   output logic [decodePkg::dataW-1:0]         pushWord,
   input  logic [$clog2(QUEUE_DEPTH+1)-1:0]   qSpace
);
   import decodePkg::*;

   logic [dataW-1:0] pc;
   logic             reqActive;  // one request on the bus at most
   logic             done;

   assign done = reqActive & wbAck;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc        <= '0;
         reqActive <= 1'b0;
      end else if (done) begin
         pc        <= pc + dataW'(2);
         reqActive <= go && (qSpace > 1);  // slot left after this push
      end else if (!reqActive) begin
         reqActive <= go && (qSpace != 0);
      end
   end

   assign wbCyc     = reqActive;
   assign wbStb     = reqActive;
   assign wbAdr     = pc;
   assign pushValid = done;
   assign pushWord  = wbDatI;

endmodule

/* instrQueue.sv */
// instruction queue
// circular buffer between fetch and decode, push and pop in one cycle
// qSpace tells fetch how many slots are free
`timescale 1ns/100ps
module instrQueue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rstN,
   input  logic                               pushValid,
   input  logic [decodePkg::dataW-1:0]         pushWord,
   output logic [$clog2(QUEUE_DEPTH+1)-1:0]   qSpace,
   output logic                               popValid,
   output logic [decodePkg::dataW-1:0]         popWord,
   input  logic                               popReady
);
   import decodePkg::*;

   localparam int ptrW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int cntW = $clog2(QUEUE_DEPTH+1);

   logic [dataW-1:0] mem [QUEUE_DEPTH];
   logic [ptrW-1:0]  wrPtr;
   logic [ptrW-1:0]  rdPtr;
   logic [cntW-1:0]  count;
   logic             pop;

   assign pop = popValid & popReady;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (pushValid) begin
            wrPtr <= (wrPtr == ptrW'(QUEUE_DEPTH-1)) ? '0 : wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= (rdPtr == ptrW'(QUEUE_DEPTH-1)) ? '0 : rdPtr + 1'b1;
         end
         count <= count + cntW'(pushValid) - cntW'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (pushValid) begin
         mem[wrPtr] <= pushWord;
      end
   end

   assign popValid = (count != '0);
   assign popWord  = mem[rdPtr];
   assign qSpace   = cntW'(QUEUE_DEPTH) - count;

endmodule

/* regFile.sv */
// register file
// eight 16-bit registers, two combinational read ports and one write port
// a write becomes visible to reads after the clock edge
`timescale 1ns/100ps
module regFile (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic [decodePkg::regSelW-1:0] rdSel1,
   input  logic [decodePkg::regSelW-1:0] rdSel2,
   input  logic [decodePkg::regSelW-1:0] wrSel,
   input  logic [decodePkg::dataW-1:0]   wrData,
   input  logic                         wrEn,
   output logic [decodePkg::dataW-1:0]   rdData1,
   output logic [decodePkg::dataW-1:0]   rdData2
);
   import decodePkg::*;

   logic [dataW-1:0] regs [2**regSelW];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 2**regSelW; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;  // writeback from the later stages
      end
   end

   assign rdData1 = regs[rdSel1];  // no bypass of a same-cycle write
   assign rdData2 = regs[rdSel2];

endmodule

/* tbDecodeSubsystem.sv */
// testbench for the decode subsystem
// wishbone memory model with random ack latency and random execute hold,
// register preload, program words and expected decode results from the trace
`timescale 1ns/100ps
module tbDecodeSubsystem;
   import decodePkg::*;

   typedef struct packed {
      logic [3:0]         aluOp;
      logic [dataW-1:0]   inA, inB, wrtData, imm8, imm11;
      logic [regSelW-1:0] wrtReg;
      logic               regWrt, memWrt, readEn;
      logic [1:0]         wbSel;
      logic [2:0]         brchSig;
      logic               jmpSel, halt, err;
   } expRec_t;

   logic               clk    = 1'b0;
   logic               rstN   = 1'b0;
   logic               go     = 1'b0;
   logic               wbAck  = 1'b0;
   logic [dataW-1:0]   wbDatI = '0;
   logic               regWrt = 1'b0;
   logic [regSelW-1:0] wrtReg = '0;
   logic [dataW-1:0]   wbData = '0;
   logic               exHold = 1'b0;
   logic               wbCyc, wbStb, wbWe, decValid;
   logic [dataW-1:0]   wbAdr, inA, inB, wrtData, imm8, imm11;
   logic [3:0]         aluOp;
   logic [regSelW-1:0] wrtRegOut;
   logic               regWrtOut, memWrt, readEn, jmpSel, halt, err;
   logic [1:0]         wbSel;
   logic [2:0]         brchSig;

   logic [dataW-1:0]   progMem [256];  // word addressed by wbAdr[8:1]
   expRec_t            expQ [$];
   logic [regSelW-1:0] preSel [$];
   logic [dataW-1:0]   preVal [$];
   int                 progLen     = 0;
   int                 ackCount    = 0;
   int                 waitCnt     = -1;  // -1 while no request is being served
   int                 checked     = 0;
   int                 mismatches  = 0;
   int                 otherErrors = 0;
   logic               runEnable   = 1'b0;
   logic [31:0]        rngState    = 32'd40484;

   decodeSubsystem #(.QUEUE_DEPTH(4)) dut0 (
      .clk(clk), .rstN(rstN), .go(go),
      .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
      .wbDatI(wbDatI), .wbAck(wbAck),
      .regWrt(regWrt), .wrtReg(wrtReg), .wbData(wbData), .exHold(exHold),
      .decValid(decValid), .aluOp(aluOp), .inA(inA), .inB(inB), .wrtData(wrtData),
      .imm8(imm8), .imm11(imm11), .wrtRegOut(wrtRegOut), .regWrtOut(regWrtOut),
      .memWrt(memWrt), .readEn(readEn), .wbSel(wbSel), .brchSig(brchSig),
      .jmpSel(jmpSel), .halt(halt), .err(err)
   );

   initial begin
      forever #4 clk = ~clk;  // 8 ns period
   end

   // 32-bit xorshift
   function automatic logic [31:0] nextRand();
      rngState ^= rngState << 13;
      rngState ^= rngState >> 17;
      rngState ^= rngState << 5;
      return rngState;
   endfunction

   task automatic compareWord(input string name, input logic [dataW-1:0] got,
                              input logic [dataW-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s on word %0d: got %h, expected %h", name, checked, got, exp);
      end
   endtask

   task automatic compareSel(input string name, input logic [regSelW-1:0] got,
                             input logic [regSelW-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s on word %0d: got %h, expected %h", name, checked, got, exp);
      end
   endtask

   task automatic compareOp(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s on word %0d: got %h, expected %h", name, checked, got, exp);
      end
   endtask

   task automatic compareWbSel(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s on word %0d: got %h, expected %h", name, checked, got, exp);
      end
   endtask

   task automatic compareBrch(input string name, input logic [2:0] got, input logic [2:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s on word %0d: got %h, expected %h", name, checked, got, exp);
      end
   endtask

   task automatic compareBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s on word %0d: got %h, expected %h", name, checked, got, exp);
      end
   endtask

   task automatic checkResult(input expRec_t e);
      compareOp("aluOp", aluOp, e.aluOp);
      compareWord("inA", inA, e.inA);
      compareWord("inB", inB, e.inB);
      compareWord("wrtData", wrtData, e.wrtData);
      compareWord("imm8", imm8, e.imm8);
      compareWord("imm11", imm11, e.imm11);
      compareSel("wrtRegOut", wrtRegOut, e.wrtReg);
      compareBit("regWrtOut", regWrtOut, e.regWrt);
      compareBit("memWrt", memWrt, e.memWrt);
      compareBit("readEn", readEn, e.readEn);
      compareWbSel("wbSel", wbSel, e.wbSel);
      compareBrch("brchSig", brchSig, e.brchSig);
      compareBit("jmpSel", jmpSel, e.jmpSel);
      compareBit("halt", halt, e.halt);
      compareBit("err", err, e.err);
   endtask

   task automatic readTrace();
      int              fd, rc, r, v;
      int              f [15];
      logic [7:0]      kind;
      logic [8*120-1:0] rest;
      expRec_t         e;
      for (int i = 0; i < 256; i++) begin
         progMem[i] = {8'(i), ~8'(i)};  // distinct fill for words past the program
      end
      fd = $fopen("decodeTrace.txt", "r");
      if (fd == 0) begin
         $display("could not open decodeTrace.txt");
         otherErrors++;
         return;
      end
      while ($fscanf(fd, " %c", kind) == 1) begin
         rc = 0;
         case (kind)
            "#": rc = $fgets(rest, fd);  // comment up to end of line
            "R": begin
               rc = $fscanf(fd, "%h %h", r, v);
               preSel.push_back(regSelW'(r));
               preVal.push_back(dataW'(v));
            end
            "P": begin
               rc = $fscanf(fd, "%h", v);
               progMem[progLen] = dataW'(v);
               progLen++;
            end
            "E": begin
               rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
               if (rc != 15) begin
                  $display("an E line of the trace has %0d fields instead of 15", rc);
                  otherErrors++;
               end
               e.aluOp   = 4'(f[0]);
               e.inA     = dataW'(f[1]);
               e.inB     = dataW'(f[2]);
               e.wrtData = dataW'(f[3]);
               e.imm8    = dataW'(f[4]);
               e.imm11   = dataW'(f[5]);
               e.wrtReg  = regSelW'(f[6]);
               e.regWrt  = 1'(f[7]);
               e.memWrt  = 1'(f[8]);
               e.readEn  = 1'(f[9]);
               e.wbSel   = 2'(f[10]);
               e.brchSig = 3'(f[11]);
               e.jmpSel  = 1'(f[12]);
               e.halt    = 1'(f[13]);
               e.err     = 1'(f[14]);
               expQ.push_back(e);
            end
            default: begin
               $display("trace line starts with unknown kind %c", kind);
               otherErrors++;
               rc = $fgets(rest, fd);
            end
         endcase
      end
      $fclose(fd);
      if (progLen == 0 || progLen != expQ.size()) begin
         $display("trace holds %0d program words but %0d expected results", progLen,
                  expQ.size());
         otherErrors++;
      end
   endtask

   // memory slave and execute hold draw from one generator in a fixed order
   always @(posedge clk) begin : busModel
      exHold <= runEnable && (nextRand() % 4 == 0);  // about a quarter of the cycles
      wbAck  <= 1'b0;
      if (wbCyc && wbStb && !wbAck) begin  // request not completed at this edge
         compareBit("wbWe", wbWe, 1'b0);
         compareWord("wbAdr", wbAdr, dataW'(2 * ackCount));  // words fetched in order from zero
         if (waitCnt < 0) begin
            waitCnt = nextRand() % 4;  // 0 to 3 idle cycles
         end
         if (waitCnt == 0) begin
            wbAck  <= 1'b1;
            wbDatI <= progMem[wbAdr[8:1]];
            ackCount++;
            waitCnt = -1;
         end else begin
            waitCnt--;
         end
      end
      go <= runEnable && (ackCount < progLen);  // low once the last word is acked
   end

   // decode output is taken by execute on an edge with exHold low
   always @(posedge clk) begin : resultCheck
      if (decValid === 1'b1 && exHold === 1'b0) begin
         if (checked >= expQ.size()) begin
            $display("decValid seen after all %0d expected results were used", expQ.size());
            otherErrors++;
         end else begin
            checkResult(expQ[checked]);
            checked++;
         end
      end
   end

   initial begin : mainFlow
      int cycles;
      int limit;
      readTrace();
      limit  = 40 * progLen + 100;
      cycles = 0;
      repeat (8) @(posedge clk);
      rstN <= 1'b1;
      @(posedge clk);
      foreach (preSel[i]) begin  // preload through the writeback port while go is low
         regWrt <= 1'b1;
         wrtReg <= preSel[i];
         wbData <= preVal[i];
         @(posedge clk);
      end
      regWrt    <= 1'b0;
      runEnable <= 1'b1;
      while (checked < expQ.size() && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      repeat (20) @(posedge clk);  // room for a stray decValid
      if (checked < expQ.size()) begin
         $display("run stopped after %0d cycles with %0d of %0d expected results unused",
                  cycles, expQ.size() - checked, expQ.size());
         otherErrors++;
      end
      $display("errors: %0d mismatches, %0d other", mismatches, otherErrors);
      if (mismatches == 0 && otherErrors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
